//--- common/hello_pkg.sv
//------------------------------------------------
// Shared types and constants for the hello-world
// register block. Holds the AXI-Lite field widths,
// the register map and the packed beats carried
// by the register slice FIFOs
//------------------------------------------------
package hello_pkg;

  // AXI-Lite field types
  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  strb_t;
  typedef logic [1:0]  resp_t;

  // Virtual LED and DIP switch vector
  typedef logic [15:0] vled_t;

  // Only response this block ever returns
  localparam resp_t RESP_OKAY = 2'b00;

  //------------------------------------------------
  // Register map
  //------------------------------------------------
  localparam addr_t HELLO_REG_ADDR = 32'h0000_0000;
  localparam addr_t VLED_REG_ADDR  = 32'h0000_0004;

  // Read data for any address outside the map
  localparam data_t UNIMPL_REG_VALUE = 32'hdead_dead;

  // Write data channel beat
  typedef struct packed {
    data_t data;
    strb_t strb;
  } w_beat_t;

  // Read data channel beat
  typedef struct packed {
    data_t data;
    resp_t resp;
  } r_beat_t;

endpackage

//--- design/axil_reg_slice/axil_chan_fifo.sv
//------------------------------------------------
// Small flop FIFO for one valid/ready channel.
// The payload type is a parameter so the same
// block serves address, data and response beats.
// Items show up on the output one cycle after
// they are accepted
//------------------------------------------------
`timescale 1ns/1ps

module axil_chan_fifo #(
  parameter int  FIFO_DEPTH = 3,
  parameter type payload_t  = logic
) (
  input  logic     clk_main_a0,
  input  logic     rst_main_n,
  input  logic     in_valid,
  input  payload_t in_data,
  output logic     in_ready,
  output logic     out_valid,
  output payload_t out_data,
  input  logic     out_ready
);

  localparam int PTR_W = $clog2(FIFO_DEPTH);
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);
  localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(FIFO_DEPTH - 1);
  localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(FIFO_DEPTH);

  payload_t         mem [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             push;
  logic             pop;

  assign in_ready  = (count < FULL_CNT);
  assign out_valid = (count != '0);
  assign push      = in_valid && in_ready;
  assign pop       = out_valid && out_ready;

  // Head entry straight from the storage flops
  assign out_data = mem[rd_ptr];

  always_ff @(posedge clk_main_a0) begin
    if (push) begin
      mem[wr_ptr] <= in_data;
    end
  end

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
      end
      count <= count + CNT_W'(push) - CNT_W'(pop);
    end
  end

  // Pointers only meet when the FIFO is empty or full, so a push never lands on the head
  a_full_blocks_push: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n)
    (wr_ptr == rd_ptr) == ((count == '0) || (count == FULL_CNT)));

  // Stalled head entry stays put
  a_out_stable: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n)
    out_valid && !out_ready |=> out_valid && $stable(out_data));

endmodule

//--- design/axil_reg_slice/axil_reg_slice.sv
//------------------------------------------------
// Register slice on the host AXI-Lite port. Each
// of the five channels runs through its own flop
// FIFO, so every direction gains one cycle and
// several transfers can sit in the slice at once
//------------------------------------------------
`timescale 1ns/1ps

module axil_reg_slice #(
  parameter int FIFO_DEPTH = 3
) (
  input  logic             clk_main_a0,
  input  logic             rst_main_n,

  // Host side
  input  logic             sh_ocl_awvalid,
  input  hello_pkg::addr_t sh_ocl_awaddr,
  output logic             ocl_sh_awready,
  input  logic             sh_ocl_wvalid,
  input  hello_pkg::data_t sh_ocl_wdata,
  input  hello_pkg::strb_t sh_ocl_wstrb,
  output logic             ocl_sh_wready,
  output logic             ocl_sh_bvalid,
  output hello_pkg::resp_t ocl_sh_bresp,
  input  logic             sh_ocl_bready,
  input  logic             sh_ocl_arvalid,
  input  hello_pkg::addr_t sh_ocl_araddr,
  output logic             ocl_sh_arready,
  output logic             ocl_sh_rvalid,
  output hello_pkg::data_t ocl_sh_rdata,
  output hello_pkg::resp_t ocl_sh_rresp,
  input  logic             sh_ocl_rready,

  // Slave side
  output logic             sh_ocl_awvalid_q,
  output hello_pkg::addr_t sh_ocl_awaddr_q,
  input  logic             ocl_sh_awready_q,
  output logic             sh_ocl_wvalid_q,
  output hello_pkg::data_t sh_ocl_wdata_q,
  output hello_pkg::strb_t sh_ocl_wstrb_q,
  input  logic             ocl_sh_wready_q,
  input  logic             ocl_sh_bvalid_q,
  input  hello_pkg::resp_t ocl_sh_bresp_q,
  output logic             sh_ocl_bready_q,
  output logic             sh_ocl_arvalid_q,
  output hello_pkg::addr_t sh_ocl_araddr_q,
  input  logic             ocl_sh_arready_q,
  input  logic             ocl_sh_rvalid_q,
  input  hello_pkg::data_t ocl_sh_rdata_q,
  input  hello_pkg::resp_t ocl_sh_rresp_q,
  output logic             sh_ocl_rready_q
);

  hello_pkg::w_beat_t w_in;
  hello_pkg::w_beat_t w_out;
  hello_pkg::r_beat_t r_in;
  hello_pkg::r_beat_t r_out;

  // Beat packing
  assign w_in.data      = sh_ocl_wdata;
  assign w_in.strb      = sh_ocl_wstrb;
  assign sh_ocl_wdata_q = w_out.data;
  assign sh_ocl_wstrb_q = w_out.strb;

  assign r_in.data    = ocl_sh_rdata_q;
  assign r_in.resp    = ocl_sh_rresp_q;
  assign ocl_sh_rdata = r_out.data;
  assign ocl_sh_rresp = r_out.resp;

  //------------------------------------------------
  // Host to slave
  //------------------------------------------------
  axil_chan_fifo #(.FIFO_DEPTH(FIFO_DEPTH), .payload_t(hello_pkg::addr_t)) aw_fifo (
    .clk_main_a0 (clk_main_a0),
    .rst_main_n  (rst_main_n),
    .in_valid    (sh_ocl_awvalid),
    .in_data     (sh_ocl_awaddr),
    .in_ready    (ocl_sh_awready),
    .out_valid   (sh_ocl_awvalid_q),
    .out_data    (sh_ocl_awaddr_q),
    .out_ready   (ocl_sh_awready_q)
  );

  axil_chan_fifo #(.FIFO_DEPTH(FIFO_DEPTH), .payload_t(hello_pkg::w_beat_t)) w_fifo (
    .clk_main_a0 (clk_main_a0),
    .rst_main_n  (rst_main_n),
    .in_valid    (sh_ocl_wvalid),
    .in_data     (w_in),
    .in_ready    (ocl_sh_wready),
    .out_valid   (sh_ocl_wvalid_q),
    .out_data    (w_out),
    .out_ready   (ocl_sh_wready_q)
  );

  axil_chan_fifo #(.FIFO_DEPTH(FIFO_DEPTH), .payload_t(hello_pkg::addr_t)) ar_fifo (
    .clk_main_a0 (clk_main_a0),
    .rst_main_n  (rst_main_n),
    .in_valid    (sh_ocl_arvalid),
    .in_data     (sh_ocl_araddr),
    .in_ready    (ocl_sh_arready),
    .out_valid   (sh_ocl_arvalid_q),
    .out_data    (sh_ocl_araddr_q),
    .out_ready   (ocl_sh_arready_q)
  );

  //------------------------------------------------
  // Slave to host
  //------------------------------------------------
  axil_chan_fifo #(.FIFO_DEPTH(FIFO_DEPTH), .payload_t(hello_pkg::resp_t)) b_fifo (
    .clk_main_a0 (clk_main_a0),
    .rst_main_n  (rst_main_n),
    .in_valid    (ocl_sh_bvalid_q),
    .in_data     (ocl_sh_bresp_q),
    .in_ready    (sh_ocl_bready_q),
    .out_valid   (ocl_sh_bvalid),
    .out_data    (ocl_sh_bresp),
    .out_ready   (sh_ocl_bready)
  );

  axil_chan_fifo #(.FIFO_DEPTH(FIFO_DEPTH), .payload_t(hello_pkg::r_beat_t)) r_fifo (
    .clk_main_a0 (clk_main_a0),
    .rst_main_n  (rst_main_n),
    .in_valid    (ocl_sh_rvalid_q),
    .in_data     (r_in),
    .in_ready    (sh_ocl_rready_q),
    .out_valid   (ocl_sh_rvalid),
    .out_data    (r_out),
    .out_ready   (sh_ocl_rready)
  );

endmodule

//--- design/ocl_slave.sv
//------------------------------------------------
// Single-beat AXI-Lite slave. Turns accepted
// write beats into register write strobes and
// read addresses into a held read address, then
// returns the responses one transfer at a time
//------------------------------------------------
`timescale 1ns/1ps

module ocl_slave (
  input  logic             clk_main_a0,
  input  logic             rst_main_n,

  input  logic             awvalid,
  input  hello_pkg::addr_t awaddr,
  output logic             awready,
  input  logic             wvalid,
  input  hello_pkg::data_t wdata,
  output logic             wready,
  output logic             bvalid,
  output hello_pkg::resp_t bresp,
  input  logic             bready,
  input  logic             arvalid,
  input  hello_pkg::addr_t araddr,
  output logic             arready,
  output logic             rvalid,
  output hello_pkg::data_t rdata,
  output hello_pkg::resp_t rresp,
  input  logic             rready,

  // Register strobes
  output logic             reg_wr_en,
  output hello_pkg::addr_t reg_wr_addr,
  output hello_pkg::data_t reg_wr_data,
  output hello_pkg::addr_t reg_rd_addr,
  input  hello_pkg::data_t reg_rd_data
);

  logic             wr_active;
  hello_pkg::addr_t wr_addr;
  logic             ar_held;
  hello_pkg::addr_t rd_addr;

  //------------------------------------------------
  // Write path
  //------------------------------------------------
  assign awready = !wr_active;

  // bvalid doubles as the response-pending flag
  assign wready = wr_active && wvalid && !bvalid;
  assign bresp  = hello_pkg::RESP_OKAY;

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n) begin
      wr_active <= 1'b0;
      bvalid    <= 1'b0;
    end else begin
      // Write ends with the response handshake
      if (bvalid && bready) begin
        wr_active <= 1'b0;
      end else if (awvalid && awready) begin
        wr_active <= 1'b1;
      end
      if (bvalid && bready) begin
        bvalid <= 1'b0;
      end else if (wvalid && wready) begin
        bvalid <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_main_a0) begin
    if (awvalid && awready) begin
      wr_addr <= awaddr;
    end
  end

  assign reg_wr_en   = wvalid && wready;
  assign reg_wr_addr = wr_addr;
  assign reg_wr_data = wdata;

  //------------------------------------------------
  // Read path
  //------------------------------------------------
  assign arready     = !ar_held && !rvalid;
  assign reg_rd_addr = rd_addr;
  assign rresp       = hello_pkg::RESP_OKAY;

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n) begin
      ar_held <= 1'b0;
      rvalid  <= 1'b0;
    end else begin
      ar_held <= arvalid && arready;
      if (rvalid && rready) begin
        rvalid <= 1'b0;
      end else if (ar_held) begin
        rvalid <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_main_a0) begin
    if (arvalid && arready) begin
      rd_addr <= araddr;
    end
    // Sample decode while the address is held
    if (ar_held) begin
      rdata <= reg_rd_data;
    end
  end

  a_r_hold: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n)
    rvalid && !rready |=> rvalid && $stable(rdata));

  // Pending response keeps its write open until bready
  a_b_hold: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n)
    bvalid && !bready |=> bvalid && wr_active);

endmodule

//--- design/hello_regs.sv
//------------------------------------------------
// Hello-world and virtual LED registers with the
// read decode. The LED register shadows the low
// half of the hello-world word and feeds the LED
// status output through the DIP switch mask
//------------------------------------------------
`timescale 1ns/1ps

module hello_regs (
  input  logic             clk_main_a0,
  input  logic             rst_main_n,
  input  logic             reg_wr_en,
  input  hello_pkg::addr_t reg_wr_addr,
  input  hello_pkg::data_t reg_wr_data,
  input  hello_pkg::addr_t reg_rd_addr,
  output hello_pkg::data_t reg_rd_data,
  input  hello_pkg::vled_t sh_cl_status_vdip,
  output hello_pkg::vled_t cl_sh_status_vled
);

  hello_pkg::data_t hello_q;
  hello_pkg::data_t hello_swapped;
  hello_pkg::vled_t vled_q;

  // Hello-world word, write only at its own offset
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n) begin
      hello_q <= '0;
    end else if (reg_wr_en && (reg_wr_addr == hello_pkg::HELLO_REG_ADDR)) begin
      hello_q <= reg_wr_data;
    end
  end

  // LED shadow trails the hello word by a cycle
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n) begin
      vled_q <= '0;
    end else begin
      vled_q <= hello_q[15:0];
    end
  end

  assign hello_swapped = {hello_q[7:0], hello_q[15:8], hello_q[23:16], hello_q[31:24]};

  //------------------------------------------------
  // Read decode
  //------------------------------------------------
  always_comb begin
    if (reg_rd_addr == hello_pkg::HELLO_REG_ADDR) begin
      reg_rd_data = hello_swapped;
    end else if (reg_rd_addr == hello_pkg::VLED_REG_ADDR) begin
      reg_rd_data = {16'h0000, vled_q};
    end else begin
      reg_rd_data = hello_pkg::UNIMPL_REG_VALUE;
    end
  end

  // LEDs only light where the DIP switch is on
  assign cl_sh_status_vled = vled_q & sh_cl_status_vdip;

endmodule

//--- design/cl_hello_world.sv
//------------------------------------------------
// Top level of the hello-world custom logic. The
// host AXI-Lite port goes through the register
// slice into the slave, which drives the register
// block. Set FIFO_DEPTH here for the slice FIFOs
//------------------------------------------------
`timescale 1ns/1ps

module cl_hello_world #(
  parameter int FIFO_DEPTH = 3
) (
  input  logic             clk_main_a0,
  input  logic             rst_main_n,

  // Host AXI-Lite port
  input  logic             sh_ocl_awvalid,
  input  hello_pkg::addr_t sh_ocl_awaddr,
  output logic             ocl_sh_awready,
  input  logic             sh_ocl_wvalid,
  input  hello_pkg::data_t sh_ocl_wdata,
  input  hello_pkg::strb_t sh_ocl_wstrb,
  output logic             ocl_sh_wready,
  output logic             ocl_sh_bvalid,
  output hello_pkg::resp_t ocl_sh_bresp,
  input  logic             sh_ocl_bready,
  input  logic             sh_ocl_arvalid,
  input  hello_pkg::addr_t sh_ocl_araddr,
  output logic             ocl_sh_arready,
  output logic             ocl_sh_rvalid,
  output hello_pkg::data_t ocl_sh_rdata,
  output hello_pkg::resp_t ocl_sh_rresp,
  input  logic             sh_ocl_rready,

  // Virtual DIP switches and LEDs
  input  hello_pkg::vled_t sh_cl_status_vdip,
  output hello_pkg::vled_t cl_sh_status_vled
);

  // Retimed port between slice and slave
  logic             sh_ocl_awvalid_q;
  hello_pkg::addr_t sh_ocl_awaddr_q;
  logic             ocl_sh_awready_q;
  logic             sh_ocl_wvalid_q;
  hello_pkg::data_t sh_ocl_wdata_q;
  hello_pkg::strb_t sh_ocl_wstrb_q;
  logic             ocl_sh_wready_q;
  logic             ocl_sh_bvalid_q;
  hello_pkg::resp_t ocl_sh_bresp_q;
  logic             sh_ocl_bready_q;
  logic             sh_ocl_arvalid_q;
  hello_pkg::addr_t sh_ocl_araddr_q;
  logic             ocl_sh_arready_q;
  logic             ocl_sh_rvalid_q;
  hello_pkg::data_t ocl_sh_rdata_q;
  hello_pkg::resp_t ocl_sh_rresp_q;
  logic             sh_ocl_rready_q;

  // Register strobes
  logic             reg_wr_en;
  hello_pkg::addr_t reg_wr_addr;
  hello_pkg::data_t reg_wr_data;
  hello_pkg::addr_t reg_rd_addr;
  hello_pkg::data_t reg_rd_data;

  axil_reg_slice #(.FIFO_DEPTH(FIFO_DEPTH)) ocl_slice (
    .clk_main_a0      (clk_main_a0),
    .rst_main_n       (rst_main_n),
    .sh_ocl_awvalid   (sh_ocl_awvalid),
    .sh_ocl_awaddr    (sh_ocl_awaddr),
    .ocl_sh_awready   (ocl_sh_awready),
    .sh_ocl_wvalid    (sh_ocl_wvalid),
    .sh_ocl_wdata     (sh_ocl_wdata),
    .sh_ocl_wstrb     (sh_ocl_wstrb),
    .ocl_sh_wready    (ocl_sh_wready),
    .ocl_sh_bvalid    (ocl_sh_bvalid),
    .ocl_sh_bresp     (ocl_sh_bresp),
    .sh_ocl_bready    (sh_ocl_bready),
    .sh_ocl_arvalid   (sh_ocl_arvalid),
    .sh_ocl_araddr    (sh_ocl_araddr),
    .ocl_sh_arready   (ocl_sh_arready),
    .ocl_sh_rvalid    (ocl_sh_rvalid),
    .ocl_sh_rdata     (ocl_sh_rdata),
    .ocl_sh_rresp     (ocl_sh_rresp),
    .sh_ocl_rready    (sh_ocl_rready),
    .sh_ocl_awvalid_q (sh_ocl_awvalid_q),
    .sh_ocl_awaddr_q  (sh_ocl_awaddr_q),
    .ocl_sh_awready_q (ocl_sh_awready_q),
    .sh_ocl_wvalid_q  (sh_ocl_wvalid_q),
    .sh_ocl_wdata_q   (sh_ocl_wdata_q),
    .sh_ocl_wstrb_q   (sh_ocl_wstrb_q),
    .ocl_sh_wready_q  (ocl_sh_wready_q),
    .ocl_sh_bvalid_q  (ocl_sh_bvalid_q),
    .ocl_sh_bresp_q   (ocl_sh_bresp_q),
    .sh_ocl_bready_q  (sh_ocl_bready_q),
    .sh_ocl_arvalid_q (sh_ocl_arvalid_q),
    .sh_ocl_araddr_q  (sh_ocl_araddr_q),
    .ocl_sh_arready_q (ocl_sh_arready_q),
    .ocl_sh_rvalid_q  (ocl_sh_rvalid_q),
    .ocl_sh_rdata_q   (ocl_sh_rdata_q),
    .ocl_sh_rresp_q   (ocl_sh_rresp_q),
    .sh_ocl_rready_q  (sh_ocl_rready_q)
  );

  // Write strobes ignored by the registers
  ocl_slave ocl_slv (
    .clk_main_a0 (clk_main_a0),
    .rst_main_n  (rst_main_n),
    .awvalid     (sh_ocl_awvalid_q),
    .awaddr      (sh_ocl_awaddr_q),
    .awready     (ocl_sh_awready_q),
    .wvalid      (sh_ocl_wvalid_q),
    .wdata       (sh_ocl_wdata_q),
    .wready      (ocl_sh_wready_q),
    .bvalid      (ocl_sh_bvalid_q),
    .bresp       (ocl_sh_bresp_q),
    .bready      (sh_ocl_bready_q),
    .arvalid     (sh_ocl_arvalid_q),
    .araddr      (sh_ocl_araddr_q),
    .arready     (ocl_sh_arready_q),
    .rvalid      (ocl_sh_rvalid_q),
    .rdata       (ocl_sh_rdata_q),
    .rresp       (ocl_sh_rresp_q),
    .rready      (sh_ocl_rready_q),
    .reg_wr_en   (reg_wr_en),
    .reg_wr_addr (reg_wr_addr),
    .reg_wr_data (reg_wr_data),
    .reg_rd_addr (reg_rd_addr),
    .reg_rd_data (reg_rd_data)
  );

  hello_regs regs (
    .clk_main_a0       (clk_main_a0),
    .rst_main_n        (rst_main_n),
    .reg_wr_en         (reg_wr_en),
    .reg_wr_addr       (reg_wr_addr),
    .reg_wr_data       (reg_wr_data),
    .reg_rd_addr       (reg_rd_addr),
    .reg_rd_data       (reg_rd_data),
    .sh_cl_status_vdip (sh_cl_status_vdip),
    .cl_sh_status_vled (cl_sh_status_vled)
  );

endmodule

//--- bench/tb_cl_hello_world.sv
//------------------------------------------------
// Testbench for the hello-world register block.
// Random AXI-Lite writes and reads run against a
// register model, with random response delays and
// LED output checks. A watchdog bounds the run
//------------------------------------------------
`timescale 1ns/1ps

module tb_cl_hello_world;

  localparam int CLK_PERIOD    = 100;
  localparam int NUM_OPS       = 400;
  localparam int CYCLES_PER_OP = 20;

  logic             clk_main_a0 = 1'b0;
  logic             rst_main_n;
  logic             sh_ocl_awvalid;
  hello_pkg::addr_t sh_ocl_awaddr;
  logic             ocl_sh_awready;
  logic             sh_ocl_wvalid;
  hello_pkg::data_t sh_ocl_wdata;
  hello_pkg::strb_t sh_ocl_wstrb;
  logic             ocl_sh_wready;
  logic             ocl_sh_bvalid;
  hello_pkg::resp_t ocl_sh_bresp;
  logic             sh_ocl_bready;
  logic             sh_ocl_arvalid;
  hello_pkg::addr_t sh_ocl_araddr;
  logic             ocl_sh_arready;
  logic             ocl_sh_rvalid;
  hello_pkg::data_t ocl_sh_rdata;
  hello_pkg::resp_t ocl_sh_rresp;
  logic             sh_ocl_rready;
  hello_pkg::vled_t sh_cl_status_vdip;
  hello_pkg::vled_t cl_sh_status_vled;

  // Model of the hello-world word
  hello_pkg::data_t hello_model;
  logic [31:0]      lcg_state;
  int               errors;
  int               checks;

  cl_hello_world #(.FIFO_DEPTH(3)) uut (
    .clk_main_a0       (clk_main_a0),
    .rst_main_n        (rst_main_n),
    .sh_ocl_awvalid    (sh_ocl_awvalid),
    .sh_ocl_awaddr     (sh_ocl_awaddr),
    .ocl_sh_awready    (ocl_sh_awready),
    .sh_ocl_wvalid     (sh_ocl_wvalid),
    .sh_ocl_wdata      (sh_ocl_wdata),
    .sh_ocl_wstrb      (sh_ocl_wstrb),
    .ocl_sh_wready     (ocl_sh_wready),
    .ocl_sh_bvalid     (ocl_sh_bvalid),
    .ocl_sh_bresp      (ocl_sh_bresp),
    .sh_ocl_bready     (sh_ocl_bready),
    .sh_ocl_arvalid    (sh_ocl_arvalid),
    .sh_ocl_araddr     (sh_ocl_araddr),
    .ocl_sh_arready    (ocl_sh_arready),
    .ocl_sh_rvalid     (ocl_sh_rvalid),
    .ocl_sh_rdata      (ocl_sh_rdata),
    .ocl_sh_rresp      (ocl_sh_rresp),
    .sh_ocl_rready     (sh_ocl_rready),
    .sh_cl_status_vdip (sh_cl_status_vdip),
    .cl_sh_status_vled (cl_sh_status_vled)
  );

  always #(CLK_PERIOD / 2) clk_main_a0 = ~clk_main_a0;

  //------------------------------------------------
  // Random numbers and expected values
  //------------------------------------------------
  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Upper LCG bits only, the low ones repeat quickly
  function automatic int rand_below(input int n);
    return int'((next_rand() >> 16) % n);
  endfunction

  function automatic hello_pkg::data_t rand_word();
    logic [31:0] hi;
    logic [31:0] lo;
    hi = next_rand();
    lo = next_rand();
    return {hi[31:16], lo[31:16]};
  endfunction

  function automatic hello_pkg::addr_t pick_addr();
    int               sel;
    hello_pkg::addr_t a;
    sel = rand_below(3);
    if (sel == 0) begin
      a = hello_pkg::HELLO_REG_ADDR;
    end else if (sel == 1) begin
      a = hello_pkg::VLED_REG_ADDR;
    end else begin
      a = (next_rand() >> 8) & 32'h0000_0ffc;
      if (a < 32'h8) begin
        a = a + 32'h8;
      end
    end
    return a;
  endfunction

  function automatic hello_pkg::data_t byte_swap(input hello_pkg::data_t w);
    return {w[7:0], w[15:8], w[23:16], w[31:24]};
  endfunction

  function automatic hello_pkg::data_t expected_read(input hello_pkg::addr_t addr);
    if (addr == hello_pkg::HELLO_REG_ADDR) begin
      return byte_swap(hello_model);
    end else if (addr == hello_pkg::VLED_REG_ADDR) begin
      return {16'h0000, hello_model[15:0]};
    end
    return hello_pkg::UNIMPL_REG_VALUE;
  endfunction

  //------------------------------------------------
  // Checks
  //------------------------------------------------
  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
    checks++;
    assert (got == exp) else begin
      errors++;
      $display("ERR %s expected %h got %h", name, exp, got);
    end
  endtask

  task automatic check_true(input bit cond, input string what);
    checks++;
    assert (cond) else begin
      errors++;
      $display("error at %0t ns: %s", $time, what);
    end
  endtask

  //------------------------------------------------
  // Bus transfers
  //------------------------------------------------
  task automatic do_write(input hello_pkg::addr_t addr, input hello_pkg::data_t data);
    bit aw_done;
    bit w_done;
    bit aw_hit;
    bit w_hit;
    int delay;
    aw_done = 1'b0;
    w_done  = 1'b0;
    delay   = rand_below(4);
    @(posedge clk_main_a0);
    sh_ocl_awvalid <= 1'b1;
    sh_ocl_awaddr  <= addr;
    sh_ocl_wvalid  <= 1'b1;
    sh_ocl_wdata   <= data;
    sh_ocl_wstrb   <= 4'hf;
    while (!(aw_done && w_done)) begin
      @(negedge clk_main_a0);
      aw_hit = sh_ocl_awvalid && ocl_sh_awready;
      w_hit  = sh_ocl_wvalid && ocl_sh_wready;
      @(posedge clk_main_a0);
      if (aw_hit) begin
        sh_ocl_awvalid <= 1'b0;
        aw_done = 1'b1;
      end
      if (w_hit) begin
        sh_ocl_wvalid <= 1'b0;
        w_done = 1'b1;
      end
    end
    @(negedge clk_main_a0);
    while (!ocl_sh_bvalid) begin
      @(negedge clk_main_a0);
    end
    // Hold off bready and watch the response stay up
    repeat (delay) begin
      @(negedge clk_main_a0);
      check_true(ocl_sh_bvalid, "bvalid dropped before bready");
    end
    @(posedge clk_main_a0);
    sh_ocl_bready <= 1'b1;
    @(negedge clk_main_a0);
    check_true(ocl_sh_bvalid, "bvalid dropped before bready");
    check_value("ocl_sh_bresp", 32'(hello_pkg::RESP_OKAY), 32'(ocl_sh_bresp));
    @(posedge clk_main_a0);
    sh_ocl_bready <= 1'b0;
    @(negedge clk_main_a0);
    check_true(!ocl_sh_bvalid, "more than one write response for a single write");
    if (addr == hello_pkg::HELLO_REG_ADDR) begin
      hello_model = data;
    end
  endtask

  task automatic do_read(input hello_pkg::addr_t addr);
    hello_pkg::data_t held;
    hello_pkg::data_t exp;
    bit               ar_hit;
    int               delay;
    delay  = rand_below(4);
    exp    = expected_read(addr);
    ar_hit = 1'b0;
    @(posedge clk_main_a0);
    sh_ocl_arvalid <= 1'b1;
    sh_ocl_araddr  <= addr;
    while (!ar_hit) begin
      @(negedge clk_main_a0);
      ar_hit = sh_ocl_arvalid && ocl_sh_arready;
      @(posedge clk_main_a0);
      if (ar_hit) begin
        sh_ocl_arvalid <= 1'b0;
      end
    end
    @(negedge clk_main_a0);
    while (!ocl_sh_rvalid) begin
      @(negedge clk_main_a0);
    end
    held = ocl_sh_rdata;
    repeat (delay) begin
      @(negedge clk_main_a0);
      check_true(ocl_sh_rvalid, "rvalid dropped before rready");
      check_value("ocl_sh_rdata", held, ocl_sh_rdata);
    end
    @(posedge clk_main_a0);
    sh_ocl_rready <= 1'b1;
    @(negedge clk_main_a0);
    check_true(ocl_sh_rvalid, "rvalid dropped before rready");
    check_value("ocl_sh_rdata", exp, ocl_sh_rdata);
    check_value("ocl_sh_rresp", 32'(hello_pkg::RESP_OKAY), 32'(ocl_sh_rresp));
    @(posedge clk_main_a0);
    sh_ocl_rready <= 1'b0;
    @(negedge clk_main_a0);
    check_true(!ocl_sh_rvalid, "more than one read response for a single read");
  endtask

  // New DIP pattern, then LEDs after two quiet cycles
  task automatic check_leds();
    hello_pkg::vled_t vdip;
    vdip = hello_pkg::vled_t'(next_rand() >> 16);
    @(posedge clk_main_a0);
    sh_cl_status_vdip <= vdip;
    @(posedge clk_main_a0);
    @(negedge clk_main_a0);
    check_value("cl_sh_status_vled", 32'(hello_model[15:0] & vdip), 32'(cl_sh_status_vled));
  endtask

  //------------------------------------------------
  // Main sequence
  //------------------------------------------------
  initial begin
    hello_pkg::addr_t addr;
    lcg_state   = 32'h30b5;
    errors      = 0;
    checks      = 0;
    hello_model = '0;
    rst_main_n        <= 1'b0;
    sh_ocl_awvalid    <= 1'b0;
    sh_ocl_awaddr     <= '0;
    sh_ocl_wvalid     <= 1'b0;
    sh_ocl_wdata      <= '0;
    sh_ocl_wstrb      <= '0;
    sh_ocl_bready     <= 1'b0;
    sh_ocl_arvalid    <= 1'b0;
    sh_ocl_araddr     <= '0;
    sh_ocl_rready     <= 1'b0;
    sh_cl_status_vdip <= '0;
    repeat (3) @(posedge clk_main_a0);
    rst_main_n <= 1'b1;

    // Both registers read zero out of reset
    do_read(hello_pkg::HELLO_REG_ADDR);
    do_read(hello_pkg::VLED_REG_ADDR);

    for (int op = 0; op < NUM_OPS; op++) begin
      addr = pick_addr();
      if (rand_below(2) == 0) begin
        do_write(addr, rand_word());
        check_leds();
      end else begin
        do_read(addr);
      end
    end

    $display("checks run %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(NUM_OPS * CYCLES_PER_OP * CLK_PERIOD);
    $display("watchdog timeout: the DUT stopped answering, run did not complete");
    $display("tests failed");
    $finish;
  end

endmodule

//--- sim.f
common/hello_pkg.sv
design/axil_reg_slice/axil_chan_fifo.sv
design/axil_reg_slice/axil_reg_slice.sv
design/ocl_slave.sv
design/hello_regs.sv
design/cl_hello_world.sv
bench/tb_cl_hello_world.sv

//--- run_sim.sh
#!/bin/sh
# Builds the hello-world testbench with Verilator, runs it
# and decides pass or fail from the simulation log.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=sim_tb
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f sim.f --top-module tb_cl_hello_world \
  -Mdir "$BUILD_DIR" -o "$SIM_BIN"
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^all tests passed$" "$LOG"; then
  echo "RESULT: PASS"
  exit 0
else
  echo "RESULT: FAIL"
  exit 1
fi
